// ==== bch_syndrome.f ====
bch_pkg.sv
lfsr_counter.sv
syndrome_ctrl.sv
syndrome_horner.sv
syndrome_report.sv
bch_syndrome_top.sv
tb_bch_syndrome.sv

// ==== Makefile ====
# Verilator flow for the BCH(15,7) syndrome stage.

TOP := tb_bch_syndrome

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module bch_syndrome_top \
		bch_pkg.sv lfsr_counter.sv syndrome_ctrl.sv syndrome_horner.sv \
		syndrome_report.sv bch_syndrome_top.sv

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f bch_syndrome.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_bch_syndrome.sv ====
//////////////////////////////////////////////////
// Testbench for the BCH(15,7) syndrome stage.
// Stops at the first mismatch. The run length is
// bounded by a watchdog scaled to the block count.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_bch_syndrome;

	localparam int unsigned clk_half = 4;
	localparam int unsigned reset_cycles = 8;
	localparam int unsigned n_rand = 16;
	localparam int unsigned n_pairs = 16;
	localparam int unsigned n_restart = 6;
	localparam int unsigned num_blocks = 1 + 4 * n_rand + 2 * n_pairs + 2 * n_restart;
	localparam int unsigned watchdog_cycles = 40 * num_blocks + reset_cycles;
	localparam logic [8:0] generator = 9'b1_1101_0001;	// x^8+x^7+x^6+x^4+1.

	logic                clk;
	logic                arst_n;
	logic                start;
	logic                ce;
	logic                data_in;
	logic                ready;
	logic                done;
	logic                errors_present;
	bch_pkg::syndromes_t syndromes;

	// Expected results in block order.
	bch_pkg::syndromes_t exp_q [$];
	string               name_q [$];

	// Input-side model of the block framing.
	logic                busy_m = 1'b0;
	int unsigned         bits_m = 0;
	logic [1:0]          done_pipe = 2'b00;
	logic                last_now = 1'b0;
	bch_pkg::syndromes_t held_syn = '0;	// Reset value until the first done.
	logic                held_err = 1'b0;
	bch_pkg::syndromes_t exp_syn = '0;
	string               exp_name = "";

	bch_syndrome_top dut0 (
		.clk            (clk),
		.arst_n         (arst_n),
		.start          (start),
		.ce             (ce),
		.data_in        (data_in),
		.ready          (ready),
		.done           (done),
		.syndromes      (syndromes),
		.errors_present (errors_present)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_half) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Direct sum of r_i * alpha^(power*i), bit 0 is x^0.
	function automatic bch_pkg::gf_elem_t eval_at(input logic [14:0] word,
			input int unsigned power);
		bch_pkg::gf_elem_t sum;
		bch_pkg::gf_elem_t term;
		logic [14:0]       w;
		sum = '0;
		term = 4'b0001;
		w = word;
		for (int unsigned i = 0; i < bch_pkg::code_n; i++) begin
			if (w[0])
				sum = sum ^ term;
			term = bch_pkg::gf_mul_const(term, power);
			w = w >> 1;
		end
		return sum;
	endfunction

	function automatic bch_pkg::syndromes_t ref_syndromes(input logic [14:0] word);
		bch_pkg::syndromes_t res;
		res.s1 = eval_at(word, 1);
		res.s2 = eval_at(word, 2);
		res.s3 = eval_at(word, 3);
		res.s4 = eval_at(word, 4);
		return res;
	endfunction

	// Systematic-free encoding, message times generator.
	function automatic logic [14:0] encode(input logic [6:0] msg);
		logic [14:0] cw;
		logic [14:0] shifted;
		logic [6:0]  m;
		cw = '0;
		shifted = 15'(generator);
		m = msg;
		for (int unsigned i = 0; i < 7; i++) begin
			if (m[0])
				cw = cw ^ shifted;
			shifted = shifted << 1;
			m = m >> 1;
		end
		return cw;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "value check");
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int unsigned n);
		repeat (n) begin
			start <= 1'b0;
			ce <= 1'b0;
			data_in <= 1'($urandom);	// Must be ignored without ce.
			@(posedge clk);
		end
	endtask

	task automatic send_block(input string name, input logic [14:0] word,
			input bch_pkg::syndromes_t expected, input int unsigned max_gap);
		logic [14:0] w;
		int unsigned gap;
		exp_q.push_back(expected);
		name_q.push_back(name);
		w = word;
		for (int unsigned i = 0; i < bch_pkg::code_n; i++) begin
			if (i != 0) begin
				gap = $urandom_range(max_gap, 0);
				idle_cycles(gap);
			end
			start <= (i == 0);
			ce <= 1'b1;
			data_in <= w[14];	// Highest power first.
			w = w << 1;
			@(posedge clk);
		end
	endtask

	// First bits of a block that is then dropped by a restart.
	task automatic send_partial(input logic [14:0] word, input int unsigned nbits);
		logic [14:0] w;
		w = word;
		for (int unsigned i = 0; i < nbits; i++) begin
			start <= (i == 0);
			ce <= 1'b1;
			data_in <= w[14];
			w = w << 1;
			@(posedge clk);
		end
	endtask

	initial begin
		logic [14:0] cw;
		logic [14:0] w;
		int unsigned pos1;
		int unsigned pos2;
		void'($urandom(53041));
		arst_n <= 1'b0;
		start <= 1'b0;
		ce <= 1'b0;
		data_in <= 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("reset ready", 16'd1, 16'(ready));
		check_value("reset done", 16'd0, 16'(done));
		check_value("reset errors_present", 16'd0, 16'(errors_present));
		check_value("reset syndromes", 16'd0, syndromes);
		@(posedge clk);

		send_block("zero block", '0, '0, 0);
		for (int unsigned k = 0; k < n_rand; k++) begin
			send_block("codeword", encode(7'($urandom)), '0, 0);	// Always clean.
			idle_cycles($urandom_range(2, 0));
		end
		for (int unsigned k = 0; k < n_rand; k++) begin
			cw = encode(7'($urandom));
			pos1 = $urandom_range(14, 0);
			w = cw ^ (15'(1) << pos1);
			send_block("single flip", w, ref_syndromes(w), 0);
			idle_cycles($urandom_range(2, 0));
		end
		for (int unsigned k = 0; k < n_rand; k++) begin
			cw = encode(7'($urandom));
			pos1 = $urandom_range(14, 0);
			do
				pos2 = $urandom_range(14, 0);
			while (pos2 == pos1);
			w = cw ^ (15'(1) << pos1) ^ (15'(1) << pos2);
			send_block("double flip", w, ref_syndromes(w), 0);
			idle_cycles($urandom_range(2, 0));
		end
		for (int unsigned k = 0; k < n_rand; k++) begin
			w = 15'($urandom);
			send_block("random word", w, ref_syndromes(w), 0);
			idle_cycles($urandom_range(2, 0));
		end

		// Same word with and without ce gaps.
		for (int unsigned k = 0; k < n_pairs; k++) begin
			w = (k % 2 == 0) ? encode(7'($urandom)) : 15'($urandom);
			send_block("gap free", w, ref_syndromes(w), 0);
			idle_cycles($urandom_range(2, 0));
			send_block("ce gaps", w, ref_syndromes(w), 3);
			idle_cycles($urandom_range(2, 0));
		end

		for (int unsigned k = 0; k < n_restart; k++) begin
			w = 15'($urandom);
			send_partial(15'($urandom), $urandom_range(14, 1));
			idle_cycles($urandom_range(2, 0));
			send_block("restart", w, ref_syndromes(w), (k % 2 == 0) ? 0 : 3);
			idle_cycles($urandom_range(2, 0));
		end

		idle_cycles(1);
		while (exp_q.size() != 0)
			@(posedge clk);
		idle_cycles(4);	// No stray done after the last block.
		$display("Testbench passed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Compare and watchdog
	//////////////////////////////////////////////////

	// Outputs are sampled mid-cycle, where they are stable.
	always @(negedge clk) begin
		if (arst_n) begin
			check_value("ready", 16'(!busy_m), 16'(ready));
			check_value("done timing", 16'(done_pipe[1]), 16'(done));
			if (done) begin
				if (exp_q.size() == 0) begin
					$display("done came with no block outstanding");
					$display("Testbench failed");
					$fatal(1, "unexpected done");
				end else begin
					exp_syn = exp_q.pop_front();
					exp_name = name_q.pop_front();
					check_value({exp_name, " syndromes"}, exp_syn, syndromes);
					check_value({exp_name, " errors_present"}, 16'(exp_syn != '0),
						16'(errors_present));
					held_syn = syndromes;
					held_err = errors_present;
				end
			end else begin
				check_value("held syndromes", held_syn, syndromes);
				check_value("held errors_present", 16'(held_err), 16'(errors_present));
			end

			// Inputs seen now are taken at the next rising edge.
			last_now = 1'b0;
			if (start && ce) begin
				busy_m = 1'b1;
				bits_m = 1;
			end else if (busy_m && ce) begin
				bits_m++;
				if (bits_m == bch_pkg::code_n) begin
					busy_m = 1'b0;
					bits_m = 0;
					last_now = 1'b1;
				end
			end
			done_pipe = {done_pipe[0], last_now};	// done two edges later.
		end
	end

	initial begin
		#(watchdog_cycles * 2 * clk_half);
		$display("Timeout: done never came for every block sent");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== bch_syndrome_top.sv ====
//////////////////////////////////////////////////
// BCH(15,7) syndrome stage, one bit per ce cycle.
// start must come with ce on the first bit.
// done is two edges after the 15th bit is taken.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bch_syndrome_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                ce,
	input  logic                data_in,
	output logic                ready,
	output logic                done,
	output bch_pkg::syndromes_t syndromes,
	output logic                errors_present
);

	bch_pkg::lfsr_count_t count;
	logic                 count_clear;
	logic                 count_step;
	logic                 acc_load;
	logic                 acc_step;
	logic                 finish;
	wire bch_pkg::odd_syn_t odd_syn;

	lfsr_counter u_counter (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (count_clear),
		.step   (count_step),
		.count  (count)
	);

	syndrome_ctrl u_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (start),
		.ce          (ce),
		.count       (count),
		.count_clear (count_clear),
		.count_step  (count_step),
		.acc_load    (acc_load),
		.acc_step    (acc_step),
		.finish      (finish),
		.ready       (ready)
	);

	syndrome_horner #(.power(1)) u_syn1 (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (acc_load),
		.step   (acc_step),
		.bit_in (data_in),
		.syn    (odd_syn.s1)
	);

	// Highest odd syndrome, S_(2t-1).
	syndrome_horner #(.power(2 * bch_pkg::code_t - 1)) u_syn3 (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (acc_load),
		.step   (acc_step),
		.bit_in (data_in),
		.syn    (odd_syn.s3)
	);

	syndrome_report u_report (
		.clk            (clk),
		.arst_n         (arst_n),
		.finish         (finish),
		.odd_syn        (odd_syn),
		.syndromes      (syndromes),
		.errors_present (errors_present),
		.done           (done)
	);

endmodule

// ==== syndrome_report.sv ====
//////////////////////////////////////////////////
// Result register. Only odd syndromes come in;
// even ones are squares for a binary code.
// Outputs hold from done until the next done.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module syndrome_report (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                finish,
	input  bch_pkg::odd_syn_t   odd_syn,
	output bch_pkg::syndromes_t syndromes,
	output logic                errors_present,
	output logic                done
);

	bch_pkg::syndromes_t expanded;

	//////////////////////////////////////////////////
	// Even syndrome expansion
	//////////////////////////////////////////////////

	always_comb begin
		expanded.s1 = odd_syn.s1;
		expanded.s2 = bch_pkg::gf_square(odd_syn.s1);	// S2 = S1^2.
		expanded.s3 = odd_syn.s3;
		expanded.s4 = bch_pkg::gf_square(expanded.s2);	// S4 = S2^2.
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syndromes      <= '0;
			errors_present <= 1'b0;
		end else if (finish) begin
			syndromes <= expanded;
			// S2 and S4 are zero exactly when S1 is.
			errors_present <= (|odd_syn.s1) || (|odd_syn.s3);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else begin
			done <= finish;	// Same edge as the results.
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Squares of a zero S1 must vanish too, so the flag covers all four.
	a_clean_no_error: assert property (
		@(posedge clk) disable iff (!arst_n)
		errors_present == (syndromes != '0)
	) else $error("errors_present disagrees with the registered syndromes");

endmodule

// ==== syndrome_horner.sv ====
//////////////////////////////////////////////////
// Horner accumulator for S_power. Bits arrive
// highest power of x first. load wins over step.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module syndrome_horner #(
	parameter int unsigned power = 1	// Syndrome index, below 15.
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              load,
	input  logic              step,
	input  logic              bit_in,
	output bch_pkg::gf_elem_t syn
);

	bch_pkg::gf_elem_t acc;
	bch_pkg::gf_elem_t acc_next;

	// r(a^p) = (..((r14 a^p + r13) a^p + r12)..) a^p + r0.
	always_comb begin
		acc_next = bch_pkg::gf_mul_const(acc, power);
		acc_next[0] = acc_next[0] ^ bit_in;	// Adding a bit touches only bit 0.
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (load) begin
			acc <= {{(bch_pkg::gf_m-1){1'b0}}, bit_in};	// Coefficient of x^14.
		end else if (step) begin
			acc <= acc_next;
		end
	end

	assign syn = acc;

endmodule

// ==== syndrome_ctrl.sv ====
//////////////////////////////////////////////////
// Block controller. start is only seen with ce.
// A start while busy drops the current block and
// restarts; no finish is issued for the old one.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module syndrome_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 start,
	input  logic                 ce,
	input  bch_pkg::lfsr_count_t count,
	output logic                 count_clear,
	output logic                 count_step,
	output logic                 acc_load,
	output logic                 acc_step,
	output logic                 finish,
	output logic                 ready
);

	bch_pkg::ctrl_state_t state;
	logic                 in_block;
	logic                 first_bit;
	logic                 last_bit;

	assign in_block  = (state == bch_pkg::busy);
	assign first_bit = start && ce;

	// Restart wins over completion of the old block.
	assign last_bit = in_block && ce && !start && (count == bch_pkg::lfsr_last);

	assign count_clear = first_bit;
	assign count_step  = in_block && ce;
	assign acc_load    = first_bit;
	assign acc_step    = in_block && ce;
	assign ready       = !in_block;

	//////////////////////////////////////////////////
	// State and finish strobe
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bch_pkg::idle;
		end else if (first_bit) begin
			state <= bch_pkg::busy;	// Bit 1 taken this edge.
		end else if (last_bit) begin
			state <= bch_pkg::idle;	// Bit 15 taken this edge.
		end
	end

	// Registered every cycle, so it is independent of ce.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			finish <= 1'b0;
		end else begin
			finish <= last_bit;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_finish_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		finish |=> !finish
	) else $error("finish held for more than one cycle");

	// A ce gap inside a block keeps ready low and the bit count frozen.
	a_hold_without_ce: assert property (
		@(posedge clk) disable iff (!arst_n)
		(!ready && !ce) |=> (!ready && $stable(count))
	) else $error("block state moved during a ce gap");

endmodule

// ==== lfsr_counter.sv ====
//////////////////////////////////////////////////
// Four-bit maximal-length LFSR, period 15.
// clear has priority over step.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lfsr_counter (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 clear,
	input  logic                 step,
	output bch_pkg::lfsr_count_t count
);

	bch_pkg::lfsr_count_t count_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= bch_pkg::lfsr_seed;	// Nonzero from the start.
		end else if (clear) begin
			count_q <= bch_pkg::lfsr_seed;	// First bit of a block.
		end else if (step) begin
			count_q <= bch_pkg::lfsr_next(count_q);
		end
	end

	assign count = count_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// The all-zero state is a lockup state for this LFSR.
	a_count_nonzero: assert property (
		@(posedge clk) disable iff (!arst_n)
		count_q != '0
	) else $error("LFSR counter reached the lockup state");

endmodule

// ==== bch_pkg.sv ====
//////////////////////////////////////////////////
// Fixed BCH(15,7) code, t=2, over GF(2^4) with
// primitive polynomial x^4+x+1. Nothing here is
// parameterized per instance.
//////////////////////////////////////////////////

package bch_pkg;

	//////////////////////////////////////////////////
	// Code constants
	//////////////////////////////////////////////////

	localparam int unsigned gf_m = 4;	// Field width.
	localparam int unsigned code_n = 15;	// Block length in bits.
	localparam int unsigned code_t = 2;	// Correctable errors.

	typedef logic [gf_m-1:0] gf_elem_t;
	typedef logic [gf_m-1:0] lfsr_count_t;

	// Low terms of x^4+x+1, folded in when x^4 appears.
	localparam gf_elem_t gf_poly_low = 4'b0011;

	localparam lfsr_count_t lfsr_seed = 4'b0001;	// Any nonzero state.

	//////////////////////////////////////////////////
	// Bundles and state
	//////////////////////////////////////////////////

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s3;
	} odd_syn_t;

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s2;
		gf_elem_t s3;
		gf_elem_t s4;
	} syndromes_t;

	typedef enum logic {
		idle = 1'b0,
		busy = 1'b1
	} ctrl_state_t;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Fibonacci step for x^4+x^3+1, period 15.
	function automatic lfsr_count_t lfsr_next(lfsr_count_t s);
		return {s[2:0], s[3] ^ s[2]};
	endfunction

	function automatic lfsr_count_t lfsr_advance(lfsr_count_t s, int unsigned steps);
		lfsr_count_t acc;
		acc = s;
		for (int unsigned i = 0; i < steps; i++)
			acc = lfsr_next(acc);
		return acc;
	endfunction

	// Seed loads with bit 1, bits 2..14 each advance once, so the 15th
	// bit is presented while the counter sits code_n-2 steps past seed.
	localparam lfsr_count_t lfsr_last = lfsr_advance(lfsr_seed, code_n - 2);

	// Multiply by alpha^power, one shift-and-reduce per power.
	function automatic gf_elem_t gf_mul_const(gf_elem_t a, int unsigned power);
		gf_elem_t acc;
		acc = a;
		for (int unsigned i = 0; i < power; i++)
			acc = {acc[gf_m-2:0], 1'b0} ^ (acc[gf_m-1] ? gf_poly_low : '0);
		return acc;
	endfunction

	// Squaring is linear in GF(2^m); x^4 = x+1, x^6 = x^3+x^2.
	function automatic gf_elem_t gf_square(gf_elem_t a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

endpackage
